/* files.f */
rv_decode_pkg.sv
dest_track_if.sv
inst_decoder.sv
dest_tracker.sv
decode_stage.sv
decode_top.sv
decode_assertions.sv
tb_decode.sv

/* tb_decode.sv */
`default_nettype none

module tb_decode;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int XLEN = 32;
  localparam int CLOCK_PERIOD = 8;
  // cycles spent by reset and all tests, plus slack for the watchdog
  localparam int TEST_CYCLES = 118;
  localparam int MARGIN_CYCLES = 100;

  logic                     clock;
  logic                     reset;
  logic [XLEN-1:0]          pc;
  rv_decode_pkg::inst_t     inst;
  logic                     inst_valid;
  logic                     block;
  logic                     clear_pipeline;
  logic                     idu_ready;
  logic                     decode_valid;
  logic [XLEN-1:0]          idu_pc;
  rv_decode_pkg::npc_sel_t  npc_sel;
  rv_decode_pkg::inst_t     imm;
  rv_decode_pkg::alu_op_t   alu_opcode;
  logic [1:0]               alu_operand1_sel;
  logic [3:0]               alu_operand2_sel;
  logic                     suffix_b;
  logic                     suffix_h;
  logic                     sext;
  logic                     mem_ren;
  logic                     mem_wen;
  rv_decode_pkg::reg_idx_t  rs1;
  rv_decode_pkg::reg_idx_t  rs2;
  rv_decode_pkg::reg_idx_t  rd;
  logic                     r_wen;
  logic [1:0]               exu_r_wdata_sel;
  rv_decode_pkg::csr_addr_t csr_s;
  logic [1:0]               csr_s_sel;
  rv_decode_pkg::csr_addr_t csr_d1;
  logic                     csr_wen1;
  logic                     csr_wen2;
  logic                     csr_wdata1_sel;
  logic                     fence_i;

  int          errors;
  int          checks;
  logic [31:0] rng_state;

  decode_top #(.XLEN(XLEN)) dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLOCK_PERIOD);
    $display("timeout: tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(1 + (next_rand() % 31));
  endfunction

  // instruction encoders following the RV32I base formats
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2_f, logic [4:0] rs1_f,
                                        logic [2:0] f3, logic [4:0] rd_f);
    return {f7, rs2_f, rs1_f, f3, rd_f, rv_decode_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] i12, logic [4:0] rs1_f, logic [2:0] f3,
                                        logic [4:0] rd_f, logic [6:0] op);
    return {i12, rs1_f, f3, rd_f, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] i12, logic [4:0] rs2_f, logic [2:0] f3);
    return {i12[11:5], rs2_f, 5'd1, f3, i12[4:0], rv_decode_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] i13, logic [2:0] f3);
    return {i13[12], i13[10:5], 5'd2, 5'd1, f3, i13[4:1], i13[11], rv_decode_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] i21, logic [4:0] rd_f);
    return {i21[20], i21[10:1], i21[11], i21[19:12], rd_f, rv_decode_pkg::OP_JAL};
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic drive(logic [31:0] word);
    inst       = word;
    inst_valid = 1'b1;
  endtask

  task automatic idle();
    inst       = '0;
    inst_valid = 1'b0;
  endtask

  // leaves the word in decode with the inputs idle
  task automatic issue(logic [31:0] word);
    drive(word);
    step();
    idle();
  endtask

  task automatic drain();
    idle();
    repeat (3) step();
  endtask

  task automatic test_immediates();
    pc = 32'h0000_1000;
    issue({20'hABCDE, 5'd5, rv_decode_pkg::OP_LUI});
    check_val("imm", imm, 32'hABCDE000);
    check_val("rs1", rs1, 0);
    check_val("idu_pc", idu_pc, 32'h0000_1000);
    issue(enc_i(12'h800, 5'd3, 3'b000, 5'd4, rv_decode_pkg::OP_IMM));
    check_val("imm", imm, 32'hFFFFF800);
    check_val("rs1", rs1, 3);
    issue(enc_s(12'h7F4, 5'd6, 3'b010));
    check_val("imm", imm, 32'h000007F4);
    check_val("rs2", rs2, 6);
    issue(enc_b(13'h1FF8, 3'b000));
    check_val("imm", imm, 32'hFFFFFFF8);
    issue(enc_j(21'h100ABC, 5'd1));
    check_val("imm", imm, 32'hFFF00ABC);
    // csr 0x305 puts a nonzero value in the rs2 field bits
    issue(enc_i(12'h305, 5'd7, 3'b001, 5'd1, rv_decode_pkg::OP_SYSTEM));
    check_val("rs2", rs2, 0);
    check_val("rs1", rs1, 7);
  endtask

  task automatic check_ops(logic [31:0] word, logic [7:0] exp_alu, logic [2:0] exp_npc,
                           logic [1:0] exp_wd, logic exp_fence);
    issue(word);
    check_val("alu_opcode", alu_opcode, exp_alu);
    check_val("npc_sel", npc_sel, exp_npc);
    check_val("exu_r_wdata_sel", exu_r_wdata_sel, exp_wd);
    check_val("fence_i", fence_i, exp_fence);
  endtask

  task automatic test_operations();
    check_ops(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 8'h00, 3'b000, 2'b00, 1'b0);
    check_ops(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 8'h01, 3'b000, 2'b00, 1'b0);
    check_ops(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), 8'h09, 3'b000, 2'b00, 1'b0);
    check_ops(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), 8'h40, 3'b000, 2'b00, 1'b0);
    check_ops(enc_b(13'h10, 3'b000), 8'h03, 3'b011, 2'b00, 1'b0);
    check_ops(enc_b(13'h10, 3'b111), 8'h11, 3'b011, 2'b00, 1'b0);
    check_ops(enc_j(21'h40, 5'd1), 8'h00, 3'b001, 2'b01, 1'b0);
    check_ops(enc_i(12'h0, 5'd1, 3'b000, 5'd1, rv_decode_pkg::OP_JALR),
              8'h00, 3'b010, 2'b01, 1'b0);
    check_ops({20'h12345, 5'd2, rv_decode_pkg::OP_AUIPC}, 8'h00, 3'b000, 2'b10, 1'b0);
    check_ops(enc_i(12'h300, 5'd1, 3'b010, 5'd2, rv_decode_pkg::OP_SYSTEM),
              8'h04, 3'b000, 2'b11, 1'b0);
    check_ops(enc_i(12'h300, 5'd1, 3'b011, 5'd2, rv_decode_pkg::OP_SYSTEM),
              8'h80, 3'b000, 2'b11, 1'b0);
    check_ops(enc_i(12'h0, 5'd0, 3'b001, 5'd0, rv_decode_pkg::OP_MISC_MEM),
              8'h00, 3'b000, 2'b00, 1'b1);
  endtask

  task automatic check_mem(logic [31:0] word, logic ren, logic wen, logic b, logic h, logic s);
    issue(word);
    step();
    check_val("mem_ren", mem_ren, ren);
    check_val("mem_wen", mem_wen, wen);
    check_val("suffix_b", suffix_b, b);
    check_val("suffix_h", suffix_h, h);
    check_val("sext", sext, s);
  endtask

  task automatic test_memory();
    check_mem(enc_i(12'h4, 5'd1, 3'b000, 5'd2, rv_decode_pkg::OP_LOAD), 1, 0, 1, 0, 1);
    check_mem(enc_i(12'h4, 5'd1, 3'b001, 5'd2, rv_decode_pkg::OP_LOAD), 1, 0, 0, 1, 1);
    check_mem(enc_i(12'h4, 5'd1, 3'b010, 5'd2, rv_decode_pkg::OP_LOAD), 1, 0, 0, 0, 0);
    check_mem(enc_i(12'h4, 5'd1, 3'b100, 5'd2, rv_decode_pkg::OP_LOAD), 1, 0, 1, 0, 0);
    check_mem(enc_i(12'h4, 5'd1, 3'b101, 5'd2, rv_decode_pkg::OP_LOAD), 1, 0, 0, 1, 0);
    check_mem(enc_s(12'h8, 5'd3, 3'b000), 0, 1, 1, 0, 0);
    check_mem(enc_s(12'h8, 5'd3, 3'b001), 0, 1, 0, 1, 0);
    check_mem(enc_s(12'h8, 5'd3, 3'b010), 0, 1, 0, 0, 0);
  endtask

  task automatic test_writeback();
    issue(enc_i(12'h10, 5'd0, 3'b000, 5'd9, rv_decode_pkg::OP_IMM));
    repeat (2) step();
    check_val("rd", rd, 9);
    check_val("r_wen", r_wen, 1);
    check_val("csr_wen1", csr_wen1, 0);
    issue({25'h0, rv_decode_pkg::OP_SYSTEM});
    check_val("csr_s", csr_s, 12'h305);
    check_val("csr_wdata1_sel", csr_wdata1_sel, 1);
    repeat (2) step();
    check_val("csr_d1", csr_d1, 12'h342);
    check_val("csr_wen1", csr_wen1, 1);
    check_val("csr_wen2", csr_wen2, 1);
    check_val("r_wen", r_wen, 0);
    issue(enc_i(12'h341, 5'd4, 3'b001, 5'd3, rv_decode_pkg::OP_SYSTEM));
    repeat (2) step();
    check_val("csr_d1", csr_d1, 12'h341);
    check_val("csr_wen1", csr_wen1, 1);
    check_val("csr_wen2", csr_wen2, 0);
    check_val("rd", rd, 3);
    check_val("r_wen", r_wen, 1);
    issue({12'h302, 13'h0, rv_decode_pkg::OP_SYSTEM});
    check_val("csr_s", csr_s, 12'h341);
  endtask

  task automatic test_hazards();
    logic [4:0] rd_a;
    logic [4:0] rd_b;
    for (int n = 0; n < 4; n++) begin
      rd_a = rand_reg();
      drain();
      drive(enc_i(12'h1, 5'd0, 3'b000, rd_a, rv_decode_pkg::OP_IMM));
      step();
      drive(enc_r(7'h00, 5'd0, rd_a, 3'b000, 5'd1));
      step();
      check_val("alu_operand1_sel", alu_operand1_sel, 2'b01);
      check_val("alu_operand2_sel", alu_operand2_sel, 4'b0000);
    end
    for (int n = 0; n < 4; n++) begin
      rd_a = rand_reg();
      rd_b = rand_reg();
      if (rd_b == rd_a) begin
        rd_b = (rd_a == 5'd31) ? 5'd1 : rd_a + 5'd1;
      end
      drain();
      drive(enc_i(12'h1, 5'd0, 3'b000, rd_a, rv_decode_pkg::OP_IMM));
      step();
      drive(enc_i(12'h2, 5'd0, 3'b000, rd_b, rv_decode_pkg::OP_IMM));
      step();
      drive(enc_r(7'h00, rd_b, rd_a, 3'b000, 5'd1));
      step();
      check_val("alu_operand1_sel", alu_operand1_sel, 2'b10);
      check_val("alu_operand2_sel", alu_operand2_sel, 4'b0100);
    end
    // csr source against the younger, then the older destination
    drain();
    drive(enc_i(12'h341, 5'd4, 3'b001, 5'd0, rv_decode_pkg::OP_SYSTEM));
    step();
    drive({12'h302, 13'h0, rv_decode_pkg::OP_SYSTEM});
    step();
    check_val("csr_s_sel", csr_s_sel, 2'b01);
    drive(enc_i(12'h341, 5'd0, 3'b010, 5'd0, rv_decode_pkg::OP_SYSTEM));
    step();
    check_val("csr_s_sel", csr_s_sel, 2'b10);
    // load-use stall
    rd_a = rand_reg();
    drain();
    drive(enc_i(12'h0, 5'd0, 3'b010, rd_a, rv_decode_pkg::OP_LOAD));
    step();
    drive(enc_r(7'h00, rd_a, 5'd0, 3'b000, 5'd1));
    #1;
    check_val("idu_ready", idu_ready, 0);
    step();
    check_val("decode_valid", decode_valid, 0);
    check_val("idu_ready", idu_ready, 1);
    step();
    check_val("decode_valid", decode_valid, 1);
    check_val("rs2", rs2, rd_a);
    idle();
  endtask

  task automatic test_block_flush();
    drain();
    pc = 32'h0000_0040;
    issue(enc_i(12'h123, 5'd0, 3'b000, 5'd7, rv_decode_pkg::OP_IMM));
    drive(enc_s(12'h4, 5'd2, 3'b010));
    pc = 32'h0000_0044;
    block = 1'b1;
    for (int n = 0; n < 4; n++) begin
      step();
      check_val("imm", imm, 32'h123);
      check_val("decode_valid", decode_valid, 1);
      check_val("idu_pc", idu_pc, 32'h40);
      check_val("mem_wen", mem_wen, 0);
      check_val("r_wen", r_wen, 0);
    end
    block = 1'b0;
    drain();
    drive(enc_i(12'h0, 5'd0, 3'b010, 5'd5, rv_decode_pkg::OP_LOAD));
    step();
    drive(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd6));
    clear_pipeline = 1'b1;
    step();
    check_val("decode_valid", decode_valid, 0);
    check_val("mem_ren", mem_ren, 0);
    clear_pipeline = 1'b0;
    idle();
    step();
    check_val("r_wen", r_wen, 0);
    check_val("rd", rd, 5);
    // a store flushed in decode never writes memory
    drive(enc_s(12'h4, 5'd2, 3'b010));
    step();
    clear_pipeline = 1'b1;
    idle();
    step();
    check_val("mem_wen", mem_wen, 0);
    clear_pipeline = 1'b0;
  endtask

  initial begin
    errors         = 0;
    checks         = 0;
    rng_state      = 32'd56;
    reset          = 1'b1;
    pc             = '0;
    inst           = '0;
    inst_valid     = 1'b0;
    block          = 1'b0;
    clear_pipeline = 1'b0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    test_immediates();
    test_operations();
    test_memory();
    test_writeback();
    test_hazards();
    test_block_flush();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* decode_assertions.sv */
`default_nettype none

module decode_assertions #(
  parameter int XLEN = 32
) (
  input logic                 clock,
  input logic                 reset,
  input logic                 block,
  input logic                 inst_valid,
  input logic                 clear_pipeline,
  input rv_decode_pkg::inst_t inst_q,
  input logic [XLEN-1:0]      idu_pc,
  input logic                 decode_valid,
  input logic                 mem_ren,
  input logic                 mem_wen,
  input logic                 is_load
);
  timeunit 1ns;
  timeprecision 100ps;

  // registers come out of reset empty
  reset_clears: assert property (@(posedge clock)
    reset |=> !decode_valid && !mem_ren && !mem_wen)
    else $error("state not cleared after reset");

  // block freezes the whole stage
  block_holds: assert property (@(posedge clock) disable iff (reset)
    block |=> $stable(inst_q) && $stable(idu_pc) && $stable(decode_valid) &&
              $stable(mem_ren) && $stable(mem_wen))
    else $error("stage changed while block was high");

  // without a load in decode every offered word is taken
  ready_without_load: assert property (@(posedge clock) disable iff (reset)
    !is_load && inst_valid && !block && !clear_pipeline |=> decode_valid)
    else $error("instruction refused without a load in decode");

endmodule

bind decode_stage decode_assertions #(.XLEN(XLEN)) assertions_i (.*);

`default_nettype wire

/* decode_top.sv */
`default_nettype none

module decode_top #(
  parameter int XLEN = 32
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [XLEN-1:0]          pc,
  input  rv_decode_pkg::inst_t     inst,
  input  logic                     inst_valid,
  input  logic                     block,
  input  logic                     clear_pipeline,
  output logic                     idu_ready,
  output logic                     decode_valid,
  output logic [XLEN-1:0]          idu_pc,
  output rv_decode_pkg::npc_sel_t  npc_sel,
  output rv_decode_pkg::inst_t     imm,
  output rv_decode_pkg::alu_op_t   alu_opcode,
  output logic [1:0]               alu_operand1_sel,
  output logic [3:0]               alu_operand2_sel,
  output logic                     suffix_b,
  output logic                     suffix_h,
  output logic                     sext,
  output logic                     mem_ren,
  output logic                     mem_wen,
  output rv_decode_pkg::reg_idx_t  rs1,
  output rv_decode_pkg::reg_idx_t  rs2,
  output rv_decode_pkg::reg_idx_t  rd,
  output logic                     r_wen,
  output logic [1:0]               exu_r_wdata_sel,
  output rv_decode_pkg::csr_addr_t csr_s,
  output logic [1:0]               csr_s_sel,
  output rv_decode_pkg::csr_addr_t csr_d1,
  output logic                     csr_wen1,
  output logic                     csr_wen2,
  output logic                     csr_wdata1_sel,
  output logic                     fence_i
);

  dest_track_if track_i ();

  decode_stage #(
    .XLEN (XLEN)
  ) stage_i (
    .clock            (clock),
    .reset            (reset),
    .pc               (pc),
    .inst             (inst),
    .inst_valid       (inst_valid),
    .block            (block),
    .clear_pipeline   (clear_pipeline),
    .idu_ready        (idu_ready),
    .decode_valid     (decode_valid),
    .idu_pc           (idu_pc),
    .imm              (imm),
    .alu_opcode       (alu_opcode),
    .npc_sel          (npc_sel),
    .alu_operand1_sel (alu_operand1_sel),
    .alu_operand2_sel (alu_operand2_sel),
    .rs1              (rs1),
    .rs2              (rs2),
    .exu_r_wdata_sel  (exu_r_wdata_sel),
    .csr_s            (csr_s),
    .csr_s_sel        (csr_s_sel),
    .csr_wdata1_sel   (csr_wdata1_sel),
    .fence_i          (fence_i),
    .suffix_b         (suffix_b),
    .suffix_h         (suffix_h),
    .sext             (sext),
    .mem_ren          (mem_ren),
    .mem_wen          (mem_wen),
    .track            (track_i.stage)
  );

  dest_tracker tracker_i (
    .clock (clock),
    .reset (reset),
    .track (track_i.tracker)
  );

  // writeback tags leave from the tracker's older stage
  assign rd       = track_i.rd;
  assign r_wen    = track_i.r_wen;
  assign csr_d1   = track_i.csr_d1;
  assign csr_wen1 = track_i.csr_wen1;
  assign csr_wen2 = track_i.csr_wen2;

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none

module decode_stage #(
  parameter int XLEN = 32
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [XLEN-1:0]          pc,
  input  rv_decode_pkg::inst_t     inst,
  input  logic                     inst_valid,
  input  logic                     block,
  input  logic                     clear_pipeline,
  output logic                     idu_ready,
  output logic                     decode_valid,
  output logic [XLEN-1:0]          idu_pc,
  output rv_decode_pkg::inst_t     imm,
  output rv_decode_pkg::alu_op_t   alu_opcode,
  output rv_decode_pkg::npc_sel_t  npc_sel,
  output logic [1:0]               alu_operand1_sel,
  output logic [3:0]               alu_operand2_sel,
  output rv_decode_pkg::reg_idx_t  rs1,
  output rv_decode_pkg::reg_idx_t  rs2,
  output logic [1:0]               exu_r_wdata_sel,
  output rv_decode_pkg::csr_addr_t csr_s,
  output logic [1:0]               csr_s_sel,
  output logic                     csr_wdata1_sel,
  output logic                     fence_i,
  output logic                     suffix_b,
  output logic                     suffix_h,
  output logic                     sext,
  output logic                     mem_ren,
  output logic                     mem_wen,
  dest_track_if.stage              track
);

  rv_decode_pkg::inst_t    inst_q;
  rv_decode_pkg::reg_idx_t rs1_in;
  rv_decode_pkg::reg_idx_t rs2_in;
  logic [1:0]              op2_base_sel;
  logic                    is_load, is_store, size_b, size_h, load_sext;
  logic                    writes_reg, writes_csr, is_ecall;
  logic                    accept;

  inst_decoder decoder_i (
    .inst_q          (inst_q),
    .imm             (imm),
    .alu_opcode      (alu_opcode),
    .npc_sel         (npc_sel),
    .op2_base_sel    (op2_base_sel),
    .rs1             (rs1),
    .rs2             (rs2),
    .csr_s           (csr_s),
    .exu_r_wdata_sel (exu_r_wdata_sel),
    .csr_wdata1_sel  (csr_wdata1_sel),
    .fence_i         (fence_i),
    .is_load         (is_load),
    .is_store        (is_store),
    .size_b          (size_b),
    .size_h          (size_h),
    .load_sext       (load_sext),
    .writes_reg      (writes_reg),
    .writes_csr      (writes_csr),
    .is_ecall        (is_ecall)
  );

  // load-use check on the incoming word against the load held in decode
  assign rs1_in    = inst[19:15];
  assign rs2_in    = inst[24:20];
  assign idu_ready = !is_load ||
                     ((rs1_in == '0 || rs1_in != inst_q[11:7]) &&
                      (rs2_in == '0 || rs2_in != inst_q[11:7]));

  assign accept = inst_valid && idu_ready && !clear_pipeline;

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_q       <= '0;
      decode_valid <= 1'b0;
      idu_pc       <= '0;
      suffix_b     <= 1'b0;
      suffix_h     <= 1'b0;
      sext         <= 1'b0;
      mem_ren      <= 1'b0;
      mem_wen      <= 1'b0;
    end else if (!block) begin
      // a bubble is an all-zero word, which decodes to nothing
      if (accept) begin
        inst_q       <= inst;
        decode_valid <= 1'b1;
        idu_pc       <= pc;
      end else begin
        inst_q       <= '0;
        decode_valid <= 1'b0;
      end

      if (clear_pipeline) begin
        suffix_b <= 1'b0;
        suffix_h <= 1'b0;
        sext     <= 1'b0;
        mem_ren  <= 1'b0;
        mem_wen  <= 1'b0;
      end else begin
        suffix_b <= size_b;
        suffix_h <= size_h;
        sext     <= load_sext;
        mem_ren  <= is_load;
        mem_wen  <= is_store;
      end
    end
  end

  // ecall writes mcause through the first CSR port
  assign track.rs1_field     = rs1;
  assign track.rs2_field     = rs2;
  assign track.csr_src       = csr_s;
  assign track.rd_next       = inst_q[11:7];
  assign track.r_wen_next    = writes_reg;
  assign track.csr_dst_next  = is_ecall ? rv_decode_pkg::CSR_MCAUSE : inst_q[31:20];
  assign track.csr_wen1_next = writes_csr;
  assign track.csr_wen2_next = is_ecall;
  assign track.flush         = clear_pipeline;
  assign track.hold          = block;

  assign alu_operand1_sel = track.op1_fwd;
  assign alu_operand2_sel = {track.op2_fwd, op2_base_sel};
  assign csr_s_sel        = track.csr_src_fwd;

endmodule

`default_nettype wire

/* dest_tracker.sv */
`default_nettype none

module dest_tracker (
  input logic         clock,
  input logic         reset,
  dest_track_if.tracker track
);

  // first stage, the instruction now in execute
  rv_decode_pkg::reg_idx_t  rd_buf;
  rv_decode_pkg::csr_addr_t csr_dst_buf;
  logic                     r_wen_buf;
  logic                     csr_wen1_buf;
  logic                     csr_wen2_buf;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_buf         <= '0;
      csr_dst_buf    <= '0;
      r_wen_buf      <= 1'b0;
      csr_wen1_buf   <= 1'b0;
      csr_wen2_buf   <= 1'b0;
      track.rd       <= '0;
      track.csr_d1   <= '0;
      track.r_wen    <= 1'b0;
      track.csr_wen1 <= 1'b0;
      track.csr_wen2 <= 1'b0;
    end else if (!track.hold) begin
      // a zero index keeps non-writing instructions out of the compares
      rd_buf      <= track.r_wen_next ? track.rd_next : '0;
      csr_dst_buf <= track.csr_dst_next;

      // flush kills the instruction leaving decode, indices move on anyway
      if (track.flush) begin
        r_wen_buf    <= 1'b0;
        csr_wen1_buf <= 1'b0;
        csr_wen2_buf <= 1'b0;
      end else begin
        r_wen_buf    <= track.r_wen_next;
        csr_wen1_buf <= track.csr_wen1_next;
        csr_wen2_buf <= track.csr_wen2_next;
      end

      // older instruction always continues to writeback
      track.rd       <= rd_buf;
      track.csr_d1   <= csr_dst_buf;
      track.r_wen    <= r_wen_buf;
      track.csr_wen1 <= csr_wen1_buf;
      track.csr_wen2 <= csr_wen2_buf;
    end
  end

  // bit 0 younger match, bit 1 older match
  assign track.op1_fwd[0] = track.rs1_field != '0 && track.rs1_field == rd_buf;
  assign track.op1_fwd[1] = track.rs1_field != '0 && track.rs1_field == track.rd;
  assign track.op2_fwd[0] = track.rs2_field != '0 && track.rs2_field == rd_buf;
  assign track.op2_fwd[1] = track.rs2_field != '0 && track.rs2_field == track.rd;

  assign track.csr_src_fwd[0] = track.csr_src != '0 && track.csr_src == csr_dst_buf;
  assign track.csr_src_fwd[1] = track.csr_src != '0 && track.csr_src == track.csr_d1;

endmodule

`default_nettype wire

/* inst_decoder.sv */
`default_nettype none

module inst_decoder (
  input  rv_decode_pkg::inst_t     inst_q,
  output rv_decode_pkg::inst_t     imm,
  output rv_decode_pkg::alu_op_t   alu_opcode,
  output rv_decode_pkg::npc_sel_t  npc_sel,
  output logic [1:0]               op2_base_sel,
  output rv_decode_pkg::reg_idx_t  rs1,
  output rv_decode_pkg::reg_idx_t  rs2,
  output rv_decode_pkg::csr_addr_t csr_s,
  output logic [1:0]               exu_r_wdata_sel,
  output logic                     csr_wdata1_sel,
  output logic                     fence_i,
  output logic                     is_load,
  output logic                     is_store,
  output logic                     size_b,
  output logic                     size_h,
  output logic                     load_sext,
  output logic                     writes_reg,
  output logic                     writes_csr,
  output logic                     is_ecall
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       f7_zero;
  logic       f7_alt;
  logic       lui, auipc, jal, jalr, branch, op_imm, op_reg, csr_op;
  logic       beq, bne, blt, bge, bltu, bgeu;
  logic       lb, lh, lbu, lhu, sb, sh;
  logic       slti, sltiu, xori, ori, andi, slli, srli, srai;
  logic       sub_r, sll_r, slt_r, sltu_r, xor_r, srl_r, sra_r, or_r, and_r;
  logic       csrrw, csrrs, csrrc, mret;
  logic       u_type, i_type;

  assign opcode  = inst_q[6:0];
  assign funct3  = inst_q[14:12];
  assign f7_zero = inst_q[31:25] == 7'b0000000;
  assign f7_alt  = inst_q[31:25] == 7'b0100000;

  // instruction classes
  assign lui      = opcode == rv_decode_pkg::OP_LUI;
  assign auipc    = opcode == rv_decode_pkg::OP_AUIPC;
  assign jal      = opcode == rv_decode_pkg::OP_JAL;
  assign jalr     = opcode == rv_decode_pkg::OP_JALR && funct3 == 3'b000;
  assign branch   = opcode == rv_decode_pkg::OP_BRANCH;
  assign is_load  = opcode == rv_decode_pkg::OP_LOAD;
  assign is_store = opcode == rv_decode_pkg::OP_STORE;
  assign op_imm   = opcode == rv_decode_pkg::OP_IMM;
  assign op_reg   = opcode == rv_decode_pkg::OP_REG;
  assign fence_i  = opcode == rv_decode_pkg::OP_MISC_MEM && funct3 == 3'b001;

  assign beq  = branch && funct3 == 3'b000;
  assign bne  = branch && funct3 == 3'b001;
  assign blt  = branch && funct3 == 3'b100;
  assign bge  = branch && funct3 == 3'b101;
  assign bltu = branch && funct3 == 3'b110;
  assign bgeu = branch && funct3 == 3'b111;

  assign lb  = is_load && funct3 == 3'b000;
  assign lh  = is_load && funct3 == 3'b001;
  assign lbu = is_load && funct3 == 3'b100;
  assign lhu = is_load && funct3 == 3'b101;
  assign sb  = is_store && funct3 == 3'b000;
  assign sh  = is_store && funct3 == 3'b001;

  assign slti  = op_imm && funct3 == 3'b010;
  assign sltiu = op_imm && funct3 == 3'b011;
  assign xori  = op_imm && funct3 == 3'b100;
  assign ori   = op_imm && funct3 == 3'b110;
  assign andi  = op_imm && funct3 == 3'b111;
  assign slli  = op_imm && funct3 == 3'b001 && f7_zero;
  assign srli  = op_imm && funct3 == 3'b101 && f7_zero;
  assign srai  = op_imm && funct3 == 3'b101 && f7_alt;

  // register ops, RV32M encodings fall through undecoded
  assign sub_r  = op_reg && funct3 == 3'b000 && f7_alt;
  assign sll_r  = op_reg && funct3 == 3'b001 && f7_zero;
  assign slt_r  = op_reg && funct3 == 3'b010 && f7_zero;
  assign sltu_r = op_reg && funct3 == 3'b011 && f7_zero;
  assign xor_r  = op_reg && funct3 == 3'b100 && f7_zero;
  assign srl_r  = op_reg && funct3 == 3'b101 && f7_zero;
  assign sra_r  = op_reg && funct3 == 3'b101 && f7_alt;
  assign or_r   = op_reg && funct3 == 3'b110 && f7_zero;
  assign and_r  = op_reg && funct3 == 3'b111 && f7_zero;

  assign csrrw    = opcode == rv_decode_pkg::OP_SYSTEM && funct3 == 3'b001;
  assign csrrs    = opcode == rv_decode_pkg::OP_SYSTEM && funct3 == 3'b010;
  assign csrrc    = opcode == rv_decode_pkg::OP_SYSTEM && funct3 == 3'b011;
  assign csr_op   = csrrw | csrrs | csrrc;
  assign is_ecall = inst_q == {25'h0, rv_decode_pkg::OP_SYSTEM};
  assign mret     = inst_q == {12'h302, 13'h0, rv_decode_pkg::OP_SYSTEM};

  assign u_type = lui | auipc;
  assign i_type = jalr | is_load | op_imm | csr_op;

  // immediate by format, zero for R-type and unknown words
  always_comb begin
    imm = '0;
    if (u_type) begin
      imm = {inst_q[31:12], 12'h0};
    end else if (jal) begin
      imm = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
    end else if (branch) begin
      imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
    end else if (i_type) begin
      imm = {{20{inst_q[31]}}, inst_q[31:20]};
    end else if (is_store) begin
      imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    end
  end

  // lui adds imm to x0, csrrw passes rs1 through with x0 as second operand
  assign rs1 = lui ? '0 : inst_q[19:15];
  assign rs2 = csrrw ? '0 : inst_q[24:20];

  assign csr_s = is_ecall ? rv_decode_pkg::CSR_MTVEC :
                 mret     ? rv_decode_pkg::CSR_MEPC  : inst_q[31:20];

  assign npc_sel = {is_ecall | mret, jalr | branch, jal | branch};

  assign op2_base_sel[0] = lui | jalr | is_load | op_imm | is_store;
  assign op2_base_sel[1] = csrrs | csrrc;

  assign exu_r_wdata_sel[0] = jal | jalr | csr_op;
  assign exu_r_wdata_sel[1] = auipc | csr_op;
  assign csr_wdata1_sel     = is_ecall;

  // an all-zero vector means add
  assign alu_opcode[rv_decode_pkg::ALU_SUB_CMP] = sub_r | branch | slti | sltiu | slt_r | sltu_r;
  assign alu_opcode[rv_decode_pkg::ALU_XOR_EQ]  = xori | xor_r | beq;
  assign alu_opcode[rv_decode_pkg::ALU_OR_NE]   = ori | or_r | bne | csrrs;
  assign alu_opcode[rv_decode_pkg::ALU_AND_LTU] = andi | and_r | bltu | sltiu | sltu_r;
  assign alu_opcode[rv_decode_pkg::ALU_SLL_GEU] = slli | sll_r | bgeu;
  assign alu_opcode[rv_decode_pkg::ALU_SRL_LT]  = srli | srl_r | blt | slti | slt_r;
  assign alu_opcode[rv_decode_pkg::ALU_SRA_GE]  = srai | sra_r | bge;
  assign alu_opcode[rv_decode_pkg::ALU_CLR]     = csrrc;

  assign size_b     = lb | lbu | sb;
  assign size_h     = lh | lhu | sh;
  assign load_sext  = lb | lh;
  assign writes_reg = u_type | jal | i_type | op_reg;
  assign writes_csr = csr_op | is_ecall;

endmodule

`default_nettype wire

/* dest_track_if.sv */
`default_nettype none

interface dest_track_if;

  // stage side, sources of the instruction in decode and its destinations
  rv_decode_pkg::reg_idx_t  rs1_field;
  rv_decode_pkg::reg_idx_t  rs2_field;
  rv_decode_pkg::csr_addr_t csr_src;
  rv_decode_pkg::reg_idx_t  rd_next;
  logic                     r_wen_next;
  rv_decode_pkg::csr_addr_t csr_dst_next;
  logic                     csr_wen1_next;
  logic                     csr_wen2_next;
  logic                     flush;
  logic                     hold;

  // tracker side, forwarding selects and the writeback tags two stages on
  logic [1:0]               op1_fwd;
  logic [1:0]               op2_fwd;
  logic [1:0]               csr_src_fwd;
  rv_decode_pkg::reg_idx_t  rd;
  logic                     r_wen;
  rv_decode_pkg::csr_addr_t csr_d1;
  logic                     csr_wen1;
  logic                     csr_wen2;

  modport stage (
    output rs1_field, rs2_field, csr_src, rd_next, r_wen_next, csr_dst_next,
           csr_wen1_next, csr_wen2_next, flush, hold,
    input  op1_fwd, op2_fwd, csr_src_fwd, rd, r_wen, csr_d1, csr_wen1, csr_wen2
  );

  modport tracker (
    input  rs1_field, rs2_field, csr_src, rd_next, r_wen_next, csr_dst_next,
           csr_wen1_next, csr_wen2_next, flush, hold,
    output op1_fwd, op2_fwd, csr_src_fwd, rd, r_wen, csr_d1, csr_wen1, csr_wen2
  );

endinterface

`default_nettype wire

/* rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

  // instruction word, also the natural pc width
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [7:0]  alu_op_t;

  // bit 0 jal or branch, bit 1 jalr or branch, bit 2 trap or return
  typedef logic [2:0]  npc_sel_t;

  // alu_op_t bit positions, arithmetic meaning first and compare meaning second
  localparam int ALU_SUB_CMP = 0;
  localparam int ALU_XOR_EQ  = 1;
  localparam int ALU_OR_NE   = 2;
  localparam int ALU_AND_LTU = 3;
  localparam int ALU_SLL_GEU = 4;
  localparam int ALU_SRL_LT  = 5;
  localparam int ALU_SRA_GE  = 6;
  localparam int ALU_CLR     = 7;

  // major opcodes
  localparam logic [6:0] OP_LUI      = 7'b0110111;
  localparam logic [6:0] OP_AUIPC    = 7'b0010111;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_LOAD     = 7'b0000011;
  localparam logic [6:0] OP_STORE    = 7'b0100011;
  localparam logic [6:0] OP_IMM      = 7'b0010011;
  localparam logic [6:0] OP_REG      = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM   = 7'b1110011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;

  // machine mode CSRs touched by trap entry and return
  localparam csr_addr_t CSR_MTVEC  = 12'h305;
  localparam csr_addr_t CSR_MEPC   = 12'h341;
  localparam csr_addr_t CSR_MCAUSE = 12'h342;

endpackage

`default_nettype wire
